// ==== compile.f ====
hdl/miniCpuPkg.sv
hdl/registerFile.sv
hdl/instrExecutor.sv
hdl/digitStage.sv
hdl/lcdTextSerializer.sv
hdl/miniCpuTop.sv
verification/tbMiniCpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tbMiniCpu -o simMiniCpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simMiniCpu > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1

// ==== verification/tbMiniCpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbMiniCpu
    import miniCpuPkg::*;
();

    localparam int ClkPeriod     = 10;
    localparam int NumInstr      = 300;
    localparam int TimeoutCycles = NumInstr * 40;

    logic                        clk;
    logic                        reset;
    instrT                       instr;
    logic                        instrValid;
    logic                        instrReady;
    logic signed [DataWidth-1:0] result;
    lcdByteT                     lcdByte;
    logic                        lcdValid;
    logic                        lcdReady;

    logic signed [DataWidth-1:0] modelRegs [16];
    logic [8:0]                  expQ [$];   // rs and data, oldest first
    logic [31:0]                 lfsrState = 32'h4d5f_869b;
    int                          errors = 0;
    int                          byteChecks = 0;
    int                          stallLeft = 0;
    logic                        stalledPrev = 1'b0;
    lcdByteT                     heldByte;

    miniCpuTop #(
        .NumDigits (5)
    ) i_miniCpuTop (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .result     (result),
        .lcdByte    (lcdByte),
        .lcdValid   (lcdValid),
        .lcdReady   (lcdReady)
    );

    initial clk = 1'b0;
    always #(ClkPeriod/2) clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic int takeBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = (v << 1) | int'(lfsrState[0]);
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // reference model: update registers, queue the seven LCD bytes
    task automatic applyModel(input instrT ins, output logic signed [15:0] res);
        logic signed [15:0] imm;
        logic signed [15:0] r2;
        int                 mag;
        int                 p;
        imm = 16'(int'(ins.operand.immForm.immMag));
        if (ins.operand.immForm.immSign) imm = -imm;
        r2 = modelRegs[ins.addr2];
        case (ins.opcode)
            OpLoad:  res = imm;
            OpAdd:   res = r2 + modelRegs[ins.operand.regForm.addr3];
            OpAddi:  res = r2 + imm;
            OpSub:   res = r2 - modelRegs[ins.operand.regForm.addr3];
            OpSubi:  res = r2 - imm;
            OpMul:   res = 16'(int'(r2) * int'(imm));   // low 16 bits
            OpClear: res = '0;
            default: res = modelRegs[ins.addr1];
        endcase
        if (ins.opcode == OpClear) begin
            for (int i = 0; i < 16; i++) modelRegs[i] = '0;
        end else if (ins.opcode != OpDisplay) begin
            modelRegs[ins.addr1] = res;
        end
        expQ.push_back({1'b0, LcdLineTwo});
        if (ins.opcode == OpClear) begin
            repeat (6) expQ.push_back({1'b1, AsciiSpace});
        end else begin
            mag = (res < 0) ? -int'(res) : int'(res);   // 32768 fits in int
            expQ.push_back({1'b1, (res < 0) ? AsciiMinus : AsciiPlus});
            for (p = 10000; p >= 1; p = p / 10) begin
                expQ.push_back({1'b1, 8'h30 + 8'((mag / p) % 10)});
            end
        end
    endtask

    // entered and left at 1 ns after a rising edge
    task automatic sendInstr(input instrT ins);
        logic signed [15:0] expRes;
        int                 gap;
        instr      = ins;
        instrValid = 1'b1;
        @(negedge clk);
        while (!instrReady) @(negedge clk);
        applyModel(ins, expRes);   // taken on the coming edge
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        checkValue("result", 32'(result), 32'(expRes));
        gap = takeBits(2);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic instrT randomInstr();
        instrT ins;
        ins.opcode = opcodeT'(takeBits(3));
        if (ins.opcode == OpClear && takeBits(2) != 0) ins.opcode = OpDisplay;   // rarer clears
        ins.addr1   = 4'(takeBits(4));
        ins.addr2   = 4'(takeBits(4));
        ins.operand = 7'(takeBits(7));
        return ins;
    endfunction

    //////////////////////////////////////////////////
    // LCD side: random stalls and byte checks
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        if (stallLeft > 0) begin
            stallLeft--;
            lcdReady = 1'b0;
        end else if (takeBits(3) == 0) begin
            stallLeft = takeBits(4);   // stretch of low ready
            lcdReady  = 1'b0;
        end else begin
            lcdReady = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (stalledPrev) begin
            if (!lcdValid) begin
                errors++;
                $display("lcdValid dropped while the byte was stalled at %0t", $time);
            end
            checkValue("lcdByte", 32'(lcdByte), 32'(heldByte));
        end
        stalledPrev = lcdValid && !lcdReady;
        heldByte    = lcdByte;
        if (lcdValid && lcdReady) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("LCD sent a byte that no instruction produced at %0t", $time);
            end else begin
                checkValue("lcdByte", 32'(lcdByte), 32'(expQ.pop_front()));
                byteChecks++;
            end
        end
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("watchdog expired with %0d LCD bytes still expected", expQ.size());
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        reset      = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        lcdReady   = 1'b0;
        for (int i = 0; i < 16; i++) modelRegs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        checkValue("lcdValid", 32'(lcdValid), 32'd0);
        checkValue("instrReady", 32'(instrReady), 32'd1);
        @(posedge clk);
        #1;
        // -32768, wrap to 32767, register add, then clear and show a zero
        sendInstr({OpLoad, 4'd1, 4'd0, 7'h20});
        sendInstr({OpMul, 4'd2, 4'd1, 7'h20});
        sendInstr({OpMul, 4'd3, 4'd2, 7'h60});
        sendInstr({OpDisplay, 4'd3, 4'd0, 7'h00});
        sendInstr({OpSubi, 4'd4, 4'd3, 7'h01});
        sendInstr({OpAdd, 4'd5, 4'd3, 7'h18});
        sendInstr({OpClear, 4'd0, 4'd0, 7'h00});
        sendInstr({OpDisplay, 4'd4, 4'd0, 7'h00});
        for (int n = 0; n < NumInstr; n++) begin
            sendInstr(randomInstr());
        end
        while (expQ.size() != 0) @(negedge clk);
        repeat (5) @(negedge clk);
        checkValue("lcdValid", 32'(lcdValid), 32'd0);
        $display("errors: %0d, LCD bytes checked: %0d", errors, byteChecks);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/miniCpuTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module miniCpuTop
    import miniCpuPkg::*;
#(
    parameter int NumDigits = 5   // 5 up to MaxDigits
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  instrT                       instr,
    input  logic                        instrValid,
    output logic                        instrReady,
    output logic signed [DataWidth-1:0] result,
    output lcdByteT                     lcdByte,
    output logic                        lcdValid,
    input  logic                        lcdReady
);

    // link 0 leaves the executor, link NumDigits enters the serializer
    digitWorkT stageWork  [NumDigits+1];
    logic      stageValid [NumDigits+1];
    logic      stageReady [NumDigits+1];

    instrExecutor i_instrExecutor (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .result     (result),
        .workOut    (stageWork[0]),
        .workValid  (stageValid[0]),
        .workReady  (stageReady[0])
    );

    //////////////////////////////////////////////////
    // decimal conversion, one digit per stage
    //////////////////////////////////////////////////
    for (genvar s = 0; s < NumDigits; s++) begin : g_digit
        digitStage #(
            .StageIndex (s)
        ) i_digitStage (
            .clk      (clk),
            .reset    (reset),
            .workIn   (stageWork[s]),
            .inValid  (stageValid[s]),
            .inReady  (stageReady[s]),
            .workOut  (stageWork[s+1]),
            .outValid (stageValid[s+1]),
            .outReady (stageReady[s+1])
        );
    end

    lcdTextSerializer #(
        .NumDigits (NumDigits)
    ) i_lcdTextSerializer (
        .clk      (clk),
        .reset    (reset),
        .workIn   (stageWork[NumDigits]),
        .inValid  (stageValid[NumDigits]),
        .inReady  (stageReady[NumDigits]),
        .lcdByte  (lcdByte),
        .lcdValid (lcdValid),
        .lcdReady (lcdReady)
    );

endmodule

`default_nettype wire

// ==== hdl/lcdTextSerializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lcdTextSerializer
    import miniCpuPkg::*;
#(
    parameter int NumDigits = 5
)
(
    input  logic      clk,
    input  logic      reset,
    input  digitWorkT workIn,
    input  logic      inValid,
    output logic      inReady,
    output lcdByteT   lcdByte,
    output logic      lcdValid,
    input  logic      lcdReady
);

    localparam int CountWidth = $clog2(NumDigits + 2);
    localparam int IdxWidth   = $clog2(MaxDigits);
    localparam int LastByte   = NumDigits + 1;   // command, sign, digits

    logic                  busy;
    digitWorkT             record;
    logic [CountWidth-1:0] byteCount;
    logic [IdxWidth-1:0]   digitIdx;
    logic [3:0]            digit;

    assign inReady  = !busy;
    assign lcdValid = busy;

    // byte 2 carries the most significant digit
    assign digitIdx = IdxWidth'(LastByte - int'(byteCount));
    assign digit    = record.digits[digitIdx];

    always_comb begin
        lcdByte.rs = 1'b1;
        if (byteCount == '0) begin
            lcdByte.rs   = 1'b0;
            lcdByte.data = LcdLineTwo;
        end else if (record.blank) begin
            lcdByte.data = AsciiSpace;
        end else if (byteCount == CountWidth'(1)) begin
            lcdByte.data = record.negative ? AsciiMinus : AsciiPlus;
        end else begin
            lcdByte.data = AsciiZero + {4'b0, digit};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            byteCount <= '0;
        end else if (!busy) begin
            busy      <= inValid;
            byteCount <= '0;
        end else if (lcdReady) begin
            if (byteCount == CountWidth'(LastByte)) begin
                busy <= 1'b0;   // last byte gone
            end
            byteCount <= byteCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            record <= workIn;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        lcdValid && !lcdReady |=> lcdValid && $stable(lcdByte))
        else $error("LCD byte changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/digitStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module digitStage
    import miniCpuPkg::*;
#(
    parameter int StageIndex = 0   // 0 gives the units digit
)
(
    input  logic      clk,
    input  logic      reset,
    input  digitWorkT workIn,
    input  logic      inValid,
    output logic      inReady,
    output digitWorkT workOut,
    output logic      outValid,
    input  logic      outReady
);

    logic                 accept;
    logic [DataWidth-1:0] quotient;
    logic [3:0]           remainder;

    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    assign quotient  = workIn.magnitude / 10;
    assign remainder = 4'(workIn.magnitude - quotient * 10);   // what the quotient leaves

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            workOut                    <= workIn;   // sign, blank, earlier digits
            workOut.magnitude          <= quotient;
            workOut.digits[StageIndex] <= remainder;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        outValid |-> workOut.digits[StageIndex] < 4'd10)
        else $error("digit stage %0d holds a digit above nine", StageIndex);

endmodule

`default_nettype wire

// ==== hdl/instrExecutor.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrExecutor
    import miniCpuPkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  instrT                       instr,
    input  logic                        instrValid,
    output logic                        instrReady,
    output logic signed [DataWidth-1:0] result,
    output digitWorkT                   workOut,
    output logic                        workValid,
    input  logic                        workReady
);

    logic                          accept;
    logic [AddrWidth-1:0]          rdAddrA;
    logic signed [DataWidth-1:0]   rdDataA;
    logic signed [DataWidth-1:0]   rdDataB;
    logic signed [DataWidth-1:0]   immExt;
    logic signed [DataWidth-1:0]   imm;
    logic signed [2*DataWidth-1:0] product;
    logic signed [DataWidth-1:0]   aluOut;
    logic signed [DataWidth-1:0]   negOut;
    logic                          writeOp;
    digitWorkT                     nextWork;

    assign instrReady = !workValid || workReady;   // slot free or draining now
    assign accept     = instrValid && instrReady;

    // DISPLAY reads addr1, everything else reads addr2
    assign rdAddrA = (instr.opcode == OpDisplay) ? instr.addr1 : instr.addr2;

    registerFile i_registerFile (
        .clk      (clk),
        .reset    (reset),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (instr.operand.regForm.addr3),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .wrEn     (accept && writeOp),
        .wrAddr   (instr.addr1),
        .wrData   (aluOut),
        .clearAll (accept && instr.opcode == OpClear)
    );

    //////////////////////////////////////////////////
    // immediate and ALU
    //////////////////////////////////////////////////
    assign immExt  = {{(DataWidth-ImmWidth){1'b0}}, instr.operand.immForm.immMag};
    assign imm     = instr.operand.immForm.immSign ? -immExt : immExt;
    assign product = rdDataA * imm;

    always_comb begin
        writeOp = 1'b1;
        case (instr.opcode)
            OpLoad:  aluOut = imm;
            OpAdd:   aluOut = rdDataA + rdDataB;
            OpAddi:  aluOut = rdDataA + imm;
            OpSub:   aluOut = rdDataA - rdDataB;
            OpSubi:  aluOut = rdDataA - imm;
            OpMul:   aluOut = product[DataWidth-1:0];   // wraps
            OpClear: begin
                aluOut  = '0;
                writeOp = 1'b0;
            end
            default: begin   // DISPLAY
                aluOut  = rdDataA;
                writeOp = 1'b0;
            end
        endcase
    end

    // -32768 negates to itself, which reads as 32768 unsigned
    assign negOut             = -aluOut;
    assign nextWork.magnitude = (aluOut < 0) ? negOut : aluOut;
    assign nextWork.digits    = '0;
    assign nextWork.negative  = aluOut < 0;
    assign nextWork.blank     = instr.opcode == OpClear;

    always_ff @(posedge clk) begin
        if (reset) begin
            workValid <= 1'b0;
            result    <= '0;
        end else if (accept) begin
            workValid <= 1'b1;
            result    <= aluOut;
        end else if (workReady) begin
            workValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            workOut <= nextWork;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile
    import miniCpuPkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [AddrWidth-1:0]        rdAddrA,
    input  logic [AddrWidth-1:0]        rdAddrB,
    output logic signed [DataWidth-1:0] rdDataA,
    output logic signed [DataWidth-1:0] rdDataB,
    input  logic                        wrEn,
    input  logic [AddrWidth-1:0]        wrAddr,
    input  logic signed [DataWidth-1:0] wrData,
    input  logic                        clearAll
);

    logic signed [DataWidth-1:0] regs [2**AddrWidth];

    // reads are combinational so a new instruction sees the last write
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (reset || clearAll) begin
            for (int i = 0; i < 2**AddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // the executor decodes these from one opcode
    assert property (@(posedge clk) disable iff (reset) !(wrEn && clearAll))
        else $error("register write and clear in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/miniCpuPkg.sv ====
`default_nettype none

package miniCpuPkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int DataWidth = 16;
    localparam int AddrWidth = 4;
    localparam int ImmWidth  = 6;
    localparam int MaxDigits = 8;   // size of the digit array in a work record

    typedef enum logic [2:0] {
        OpLoad    = 3'd0,
        OpAdd     = 3'd1,
        OpAddi    = 3'd2,
        OpSub     = 3'd3,
        OpSubi    = 3'd4,
        OpMul     = 3'd5,
        OpClear   = 3'd6,
        OpDisplay = 3'd7
    } opcodeT;

    // same seven switches, read as a third address or as an immediate
    typedef struct packed {
        logic [AddrWidth-1:0] addr3;
        logic [2:0]           unused;
    } regFormT;

    typedef struct packed {
        logic                immSign;   // set means negative
        logic [ImmWidth-1:0] immMag;
    } immFormT;

    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } operandU;

    typedef struct packed {
        opcodeT               opcode;
        logic [AddrWidth-1:0] addr1;
        logic [AddrWidth-1:0] addr2;
        operandU              operand;
    } instrT;

    typedef struct packed {
        logic [DataWidth-1:0]          magnitude;   // not yet converted part
        logic [MaxDigits-1:0][3:0]     digits;      // entry 0 is the units digit
        logic                          negative;
        logic                          blank;       // CLEAR shows spaces
    } digitWorkT;

    typedef struct packed {
        logic       rs;     // 0 command, 1 character
        logic [7:0] data;
    } lcdByteT;

    //////////////////////////////////////////////////
    // LCD codes
    //////////////////////////////////////////////////
    localparam logic [7:0] LcdLineTwo = 8'hC0;
    localparam logic [7:0] AsciiZero  = 8'h30;
    localparam logic [7:0] AsciiSpace = 8'h20;
    localparam logic [7:0] AsciiPlus  = 8'h2B;
    localparam logic [7:0] AsciiMinus = 8'h2D;

endpackage

`default_nettype wire
